//--- verilog/gpio_pkg.sv
////////////////////
// Shared widths, register map and request types of the GPIO peripheral
// Imported by every RTL module and by the testbench reference model
////////////////////

package gpio_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Number of GPIO pins
  localparam int unsigned gpio_width     = 8;
  // Bus side widths
  localparam int unsigned bus_data_width = 32;
  localparam int unsigned bus_addr_width = 32;
  // Only the low address bits are decoded, so the map aliases every 16 bytes
  localparam int unsigned reg_addr_width = 4;

  typedef logic [gpio_width-1:0]     gpio_t;
  typedef logic [bus_data_width-1:0] bus_data_t;
  typedef logic [bus_addr_width-1:0] bus_addr_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  ////////////////////
  // Register map
  ////////////////////

  // Output enable, read/write
  localparam reg_addr_t reg_oe_offset   = 4'h0;
  // Output value, read/write
  localparam reg_addr_t reg_out_offset  = 4'h4;
  // Synchronized pins, read only
  localparam reg_addr_t reg_in_offset   = 4'h8;
  // Sticky rising edges, write 1 to clear
  localparam reg_addr_t reg_edge_offset = 4'hC;

  // Only OKAY is ever returned
  localparam logic [1:0] resp_okay = 2'b00;

  // One-cycle register write from the write unit
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    bus_data_t data;
  } reg_write_t;

  // Read request from the read unit, answered in the same cycle
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
  } reg_read_t;

endpackage

//--- verilog/axil_write_unit.sv
////////////////////
// AXI4-lite write side of the GPIO peripheral
// Accepts AW and W together, issues one register write, returns B
////////////////////

`timescale 1ns/1ns

module axil_write_unit (
  input  logic                   bus,
  input  logic                   reset,
  // Write address channel
  input  logic                   awvalid,
  output logic                   awready,
  input  gpio_pkg::bus_addr_t    awaddr,
  // Write data channel
  input  logic                   wvalid,
  output logic                   wready,
  input  gpio_pkg::bus_data_t    wdata,
  // Write response channel
  output logic                   bvalid,
  input  logic                   bready,
  output logic [1:0]             bresp,
  // Request towards the register block
  output gpio_pkg::reg_write_t   wr_req
);

  import gpio_pkg::*;

  logic accept;

  ////////////////////
  // Address and data acceptance
  ////////////////////

  // Both beats must be present, and no response may be pending
  assign accept  = awvalid & wvalid & ~bvalid;

  // AW and W are always taken in the same cycle
  assign awready = accept;
  assign wready  = accept;

  // Write request lives for the acceptance cycle only
  assign wr_req.valid = accept;
  // Upper address bits ignored
  assign wr_req.addr  = reg_addr_t'(awaddr);
  assign wr_req.data  = wdata;

  ////////////////////
  // Write response
  ////////////////////

  // Set after acceptance, held until the master takes it
  always_ff @(posedge bus) begin
    if (reset) begin
      bvalid <= 1'b0;
    end else if (accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // No error responses
  assign bresp = resp_okay;

endmodule

//--- verilog/axil_read_unit.sv
////////////////////
// AXI4-lite read side of the GPIO peripheral
// Takes one AR beat, looks up the register, returns a registered R beat
////////////////////

`timescale 1ns/1ns

module axil_read_unit (
  input  logic                  bus,
  input  logic                  reset,
  // Read address channel
  input  logic                  arvalid,
  output logic                  arready,
  input  gpio_pkg::bus_addr_t   araddr,
  // Read data channel
  output logic                  rvalid,
  input  logic                  rready,
  output gpio_pkg::bus_data_t   rdata,
  output logic [1:0]            rresp,
  // Lookup in the register block
  output gpio_pkg::reg_read_t   rd_req,
  input  gpio_pkg::bus_data_t   rd_data
);

  import gpio_pkg::*;

  logic accept;

  ////////////////////
  // Address acceptance
  ////////////////////

  // One read at a time, blocked while R is pending
  assign accept  = arvalid & ~rvalid;
  assign arready = accept;

  // Offset goes to the register block in the acceptance cycle
  assign rd_req.valid = accept;
  assign rd_req.addr  = reg_addr_t'(araddr);

  ////////////////////
  // Read response
  ////////////////////

  // Response valid, held under back-pressure
  always_ff @(posedge bus) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Data captured at acceptance and frozen until the next accept
  always_ff @(posedge bus) begin
    if (accept) begin
      rdata <= rd_data;
    end
  end

  assign rresp = resp_okay;

endmodule

//--- verilog/gpio_input_sync.sv
////////////////////
// Brings the gpio_i pins into the bus clock domain
// Also flags each rising edge for one cycle
////////////////////

`timescale 1ns/1ns

module gpio_input_sync (
  input  logic            bus,
  input  logic            reset,
  input  gpio_pkg::gpio_t gpio_i,
  output gpio_pkg::gpio_t sync_in,
  output gpio_pkg::gpio_t rise
);

  import gpio_pkg::*;

  // First stage may go metastable
  gpio_t sync_q1;
  // Second stage, safe to use
  gpio_t sync_q2;
  // Previous synchronized value, for edge detection
  gpio_t prev_q;

  ////////////////////
  // Synchronizer
  ////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  // Pin state seen 2 cycles after the pin moved
  assign sync_in = sync_q2;

  // High in the first cycle a bit reads 1
  assign rise = sync_q2 & ~prev_q;

endmodule

//--- verilog/gpio_regs.sv
////////////////////
// GPIO register block
// Applies write requests, answers read requests in the same cycle,
// and drives the pin enables and values
////////////////////

`timescale 1ns/1ns

module gpio_regs (
  input  logic                  bus,
  input  logic                  reset,
  // Requests from the bus units
  input  gpio_pkg::reg_write_t  wr_req,
  input  gpio_pkg::reg_read_t   rd_req,
  output gpio_pkg::bus_data_t   rd_data,
  // Synchronized pin state
  input  gpio_pkg::gpio_t       sync_in,
  input  gpio_pkg::gpio_t       rise,
  // Pin drivers
  output gpio_pkg::gpio_t       gpio_e,
  output gpio_pkg::gpio_t       gpio_o
);

  import gpio_pkg::*;

  // Sticky edge status
  gpio_t edge_q;

  // Write decode
  logic  wr_oe;
  logic  wr_out;
  logic  wr_edge;
  gpio_t wr_bits;
  gpio_t edge_clear;

  // Read mux result before the valid gate
  bus_data_t rd_word;

  ////////////////////
  // Write decode
  ////////////////////

  assign wr_oe   = wr_req.valid && (wr_req.addr == reg_oe_offset);
  assign wr_out  = wr_req.valid && (wr_req.addr == reg_out_offset);
  assign wr_edge = wr_req.valid && (wr_req.addr == reg_edge_offset);

  // Only the low pin bits of the bus word matter
  assign wr_bits = gpio_t'(wr_req.data);

  // Bits written as 1 are cleared, 0 leaves them alone
  assign edge_clear = wr_edge ? wr_bits : '0;

  ////////////////////
  // Registers
  ////////////////////

  // Output enable and value, whole register replaced
  // Writes to the input offset fall through and do nothing
  always_ff @(posedge bus) begin
    if (reset) begin
      gpio_e <= '0;
      gpio_o <= '0;
    end else begin
      if (wr_oe) begin
        gpio_e <= wr_bits;
      end
      if (wr_out) begin
        gpio_o <= wr_bits;
      end
    end
  end

  // A new rising edge beats a clear in the same cycle
  always_ff @(posedge bus) begin
    if (reset) begin
      edge_q <= '0;
    end else begin
      edge_q <= (edge_q & ~edge_clear) | rise;
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  // Current state, so a write in the same cycle is not yet visible
  always_comb begin
    case (rd_req.addr)
      reg_oe_offset:   rd_word = bus_data_t'(gpio_e);
      reg_out_offset:  rd_word = bus_data_t'(gpio_o);
      reg_in_offset:   rd_word = bus_data_t'(sync_in);
      reg_edge_offset: rd_word = bus_data_t'(edge_q);
      // Unmapped offsets read as zero
      default:         rd_word = '0;
    endcase
  end

  assign rd_data = rd_req.valid ? rd_word : '0;

endmodule

//--- verilog/gpio_top.sv
////////////////////
// GPIO peripheral top level
// Flat AXI4-lite slave port on one side, GPIO pins on the other
////////////////////

`timescale 1ns/1ns

module gpio_top (
  input  logic                 bus,
  input  logic                 reset,
  // Write address channel
  input  logic                 awvalid,
  output logic                 awready,
  input  gpio_pkg::bus_addr_t  awaddr,
  // Write data channel
  input  logic                 wvalid,
  output logic                 wready,
  input  gpio_pkg::bus_data_t  wdata,
  // Write response channel
  output logic                 bvalid,
  input  logic                 bready,
  output logic [1:0]           bresp,
  // Read address channel
  input  logic                 arvalid,
  output logic                 arready,
  input  gpio_pkg::bus_addr_t  araddr,
  // Read data channel
  output logic                 rvalid,
  input  logic                 rready,
  output gpio_pkg::bus_data_t  rdata,
  output logic [1:0]           rresp,
  // Pins
  output gpio_pkg::gpio_t      gpio_e,
  output gpio_pkg::gpio_t      gpio_o,
  input  gpio_pkg::gpio_t      gpio_i
);

  import gpio_pkg::*;

  // Requests into the register block
  reg_write_t wr_req;
  reg_read_t  rd_req;
  bus_data_t  rd_data;

  // Synchronized pins
  gpio_t sync_in;
  gpio_t rise;

  ////////////////////
  // Bus units
  ////////////////////

  axil_write_unit write_unit_i (
    .bus     (bus),
    .reset   (reset),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .wr_req  (wr_req)
  );

  axil_read_unit read_unit_i (
    .bus     (bus),
    .reset   (reset),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rd_req  (rd_req),
    .rd_data (rd_data)
  );

  ////////////////////
  // Pin side
  ////////////////////

  gpio_input_sync input_sync_i (
    .bus     (bus),
    .reset   (reset),
    .gpio_i  (gpio_i),
    .sync_in (sync_in),
    .rise    (rise)
  );

  gpio_regs regs_i (
    .bus     (bus),
    .reset   (reset),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_data (rd_data),
    .sync_in (sync_in),
    .rise    (rise),
    .gpio_e  (gpio_e),
    .gpio_o  (gpio_o)
  );

endmodule

//--- testbench/gpio_checker.sv
////////////////////
// Bus protocol assertions for the GPIO peripheral
// Bound into gpio_top, watches the handshake signals only
////////////////////

`timescale 1ns/1ns

module gpio_checker (
  input logic                bus,
  input logic                reset,
  input logic                awready,
  input logic                wready,
  input logic                arready,
  input logic                bvalid,
  input logic                bready,
  input logic                rvalid,
  input logic                rready,
  input gpio_pkg::bus_data_t rdata
);

  // Failed assertions so far, read by the testbench at the end
  int unsigned assert_fails = 0;

  ////////////////////
  // Response channels
  ////////////////////

  // B held until taken
  bvalid_hold: assert property (@(posedge bus) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else begin
      assert_fails++;
      $error("bvalid dropped before bready");
    end

  // R held until taken
  rvalid_hold: assert property (@(posedge bus) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else begin
      assert_fails++;
      $error("rvalid dropped before rready");
    end

  // Read word frozen under back-pressure
  rdata_stable: assert property (@(posedge bus) disable iff (reset)
    rvalid && !rready |=> $stable(rdata))
    else begin
      assert_fails++;
      $error("rdata changed while waiting for rready");
    end

  ////////////////////
  // Ready signals
  ////////////////////

  // AW and W always taken together
  aw_w_paired: assert property (@(posedge bus) awready == wready)
    else begin
      assert_fails++;
      $error("awready and wready differ");
    end

  // Nothing accepted in reset
  ready_in_reset: assert property (@(posedge bus)
    reset |-> !awready && !wready && !arready)
    else begin
      assert_fails++;
      $error("ready high during reset");
    end

endmodule

bind gpio_top gpio_checker checker_i (
  .bus     (bus),
  .reset   (reset),
  .awready (awready),
  .wready  (wready),
  .arready (arready),
  .bvalid  (bvalid),
  .bready  (bready),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata)
);

//--- testbench/gpio_tb.sv
////////////////////
// Testbench for the GPIO peripheral
// Drives the AXI4-lite port and the pins and checks reads against a model
////////////////////

`timescale 1ns/1ns

module gpio_tb;

  import gpio_pkg::*;

  localparam int timeout_cycles = 100;

  // DUT ports
  logic      bus;
  logic      reset;
  logic      awvalid;
  logic      awready;
  bus_addr_t awaddr;
  logic      wvalid;
  logic      wready;
  bus_data_t wdata;
  logic      bvalid;
  logic      bready;
  logic [1:0] bresp;
  logic      arvalid;
  logic      arready;
  bus_addr_t araddr;
  logic      rvalid;
  logic      rready;
  bus_data_t rdata;
  logic [1:0] rresp;
  gpio_t     gpio_e;
  gpio_t     gpio_o;
  gpio_t     gpio_i;

  // Register model
  gpio_t model_oe;
  gpio_t model_out;
  gpio_t model_in;
  gpio_t model_edge;

  // Expected read words in arrival order
  bus_data_t expected_q[$];
  bus_data_t expected_rdata;

  logic [15:0] lfsr_state = 16'd54;
  int error_count = 0;
  int pass_count = 0;
  int errors_at_start;
  int aw_count = 0;
  int b_count = 0;

  gpio_top dut_i (.*);

  ////////////////////
  // Clock
  ////////////////////

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  ////////////////////
  // Random numbers
  ////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic bus_data_t random_bits(input int n);
    bus_data_t value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], next_bit()};
    end
    return value;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Word a read of this offset must return
  function automatic bus_data_t expected_word(input logic [3:0] offset);
    case (offset)
      4'h0:    return {24'h0, model_oe};
      4'h4:    return {24'h0, model_out};
      4'h8:    return {24'h0, model_in};
      4'hC:    return {24'h0, model_edge};
      default: return '0;
    endcase
  endfunction

  // Register effect of one accepted write
  task automatic apply_write(input logic [3:0] offset, input bus_data_t data);
    case (offset)
      4'h0:    model_oe = data[7:0];
      4'h4:    model_out = data[7:0];
      4'hC:    model_edge = model_edge & ~data[7:0];
      default: ;
    endcase
  endtask

  task automatic report_mismatch(input string name, input bus_data_t expected,
                                 input bus_data_t actual);
    $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("%0t ns: %s", $time, what);
    error_count++;
  endtask

  ////////////////////
  // Bus tasks
  ////////////////////

  // Advance to the drive point of the next cycle
  task automatic next_cycle();
    @(posedge bus);
    #1;
  endtask

  task automatic write_reg(input bus_addr_t addr, input bus_data_t data, input int bdelay);
    int   cycles;
    logic seen;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    cycles  = 0;
    seen    = 1'b0;
    while (!seen && cycles < timeout_cycles) begin
      @(negedge bus);
      seen = awready && wready;
      if (seen) apply_write(addr[3:0], data);
      next_cycle();
      cycles++;
    end
    if (!seen) begin
      awvalid = 1'b0;
      wvalid  = 1'b0;
      report_failure("write was never accepted");
      return;
    end
    // Another beat offered while B waits must be refused
    repeat (bdelay) begin
      @(negedge bus);
      if (awready) report_failure("write accepted while a response was pending");
      next_cycle();
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    cycles  = 0;
    seen    = 1'b0;
    while (!seen && cycles < timeout_cycles) begin
      @(negedge bus);
      seen = bvalid;
      if (seen) begin
        // Pins already updated when B shows up
        if (bresp !== resp_okay) report_mismatch("bresp", 32'(resp_okay), 32'(bresp));
        else pass_count++;
        if (gpio_e !== model_oe) report_mismatch("gpio_e", 32'(model_oe), 32'(gpio_e));
        else pass_count++;
        if (gpio_o !== model_out) report_mismatch("gpio_o", 32'(model_out), 32'(gpio_o));
        else pass_count++;
      end
      next_cycle();
      cycles++;
    end
    bready = 1'b0;
    if (!seen) report_failure("write response never arrived");
  endtask

  task automatic read_reg(input bus_addr_t addr, input int rdelay);
    int   cycles;
    logic seen;
    araddr  = addr;
    arvalid = 1'b1;
    cycles  = 0;
    seen    = 1'b0;
    while (!seen && cycles < timeout_cycles) begin
      @(negedge bus);
      seen = arready;
      if (seen) expected_q.push_back(expected_word(addr[3:0]));
      next_cycle();
      cycles++;
    end
    if (!seen) begin
      arvalid = 1'b0;
      report_failure("read was never accepted");
      return;
    end
    repeat (rdelay) begin
      @(negedge bus);
      if (arready) report_failure("read accepted while a response was pending");
      next_cycle();
    end
    arvalid = 1'b0;
    rready  = 1'b1;
    cycles  = 0;
    seen    = 1'b0;
    // Data itself is compared by the monitor below
    while (!seen && cycles < timeout_cycles) begin
      @(negedge bus);
      seen = rvalid;
      next_cycle();
      cycles++;
    end
    rready = 1'b0;
    if (!seen) report_failure("read response never arrived");
  endtask

  // New pin pattern plus enough cycles for sync and edge status
  task automatic set_pins(input gpio_t pattern);
    gpio_i     = pattern;
    model_edge = model_edge | (pattern & ~model_in);
    model_in   = pattern;
    repeat (4) next_cycle();
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  // Sampled mid-cycle so each handshake is seen once
  always @(negedge bus) begin
    if (!reset) begin
      if (awvalid && awready) aw_count++;
      if (bvalid && bready) b_count++;
      if (rvalid && rready) begin
        if (expected_q.size() == 0) begin
          report_failure("read response with no read outstanding");
        end else begin
          expected_rdata = expected_q.pop_front();
          if (rdata !== expected_rdata) report_mismatch("rdata", expected_rdata, rdata);
          else pass_count++;
          if (rresp !== resp_okay) report_mismatch("rresp", 32'(resp_okay), 32'(rresp));
          else pass_count++;
        end
      end
    end
  end

  task automatic begin_test();
    errors_at_start = error_count;
  endtask

  task automatic end_test(input string name);
    if (error_count == errors_at_start) $display("%s: passed", name);
    else $display("%s: failed with %0d errors", name, error_count - errors_at_start);
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    bus_data_t rnd;
    bus_data_t data;
    bus_addr_t addr;
    logic [3:0] offset;
    int total_errors;
    reset   = 1'b1;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    gpio_i  = '0;
    model_oe   = '0;
    model_out  = '0;
    model_in   = '0;
    model_edge = '0;
    repeat (10) @(posedge bus);
    #1;
    reset = 1'b0;

    // 1. Everything zero out of reset
    begin_test();
    if (gpio_e !== 8'h00) report_mismatch("gpio_e", 32'h0, 32'(gpio_e));
    else pass_count++;
    if (gpio_o !== 8'h00) report_mismatch("gpio_o", 32'h0, 32'(gpio_o));
    else pass_count++;
    for (int i = 0; i < 4; i++) read_reg(bus_addr_t'(i * 4), 0);
    end_test("reset values");

    // 2. Output registers through plain and aliased addresses
    begin_test();
    for (int i = 0; i < 8; i++) begin
      rnd    = random_bits(2);
      offset = rnd[0] ? 4'h4 : 4'h0;
      addr   = {28'h0, offset};
      if (rnd[1]) addr = addr + 32'h10;
      write_reg(addr, random_bits(32), 0);
      rnd = random_bits(1);
      read_reg(rnd[0] ? 32'h10 : 32'h0, 0);
      read_reg(rnd[0] ? 32'h4 : 32'h14, 0);
    end
    end_test("output registers");

    // 3. Input register follows the pins and ignores writes
    begin_test();
    for (int i = 0; i < 4; i++) begin
      rnd = random_bits(8);
      set_pins(rnd[7:0]);
      read_reg(32'h8, 0);
      write_reg(32'h8, random_bits(32), 0);
      read_reg(32'h8, 0);
    end
    end_test("input register");

    // 4. Sticky edges cleared by writing 1
    begin_test();
    set_pins(8'h00);
    write_reg(32'hC, 32'hFF, 0);
    read_reg(32'hC, 0);
    set_pins(8'hFF);
    read_reg(32'hC, 0);
    rnd = random_bits(8);
    write_reg(32'hC, {24'h0, rnd[7:0]}, 0);
    read_reg(32'hC, 0);
    write_reg(32'hC, 32'hFF, 0);
    read_reg(32'hC, 0);
    end_test("edge status");

    // 5. Random response back-pressure
    begin_test();
    for (int i = 0; i < 12; i++) begin
      rnd  = random_bits(1);
      data = random_bits(32);
      write_reg(rnd[0] ? 32'h4 : 32'h0, data, int'(random_bits(3)));
      rnd = random_bits(2);
      read_reg({28'h0, rnd[1:0], 2'b00}, int'(random_bits(3)));
    end
    end_test("back-pressure");

    // 6. Holes in the map
    begin_test();
    // Every mapped register nonzero, so a loose decode shows up
    write_reg(32'h0, 32'hA5, 0);
    write_reg(32'h4, 32'h5A, 0);
    set_pins(8'h00);
    set_pins(8'h3C);
    read_reg(32'h1, 0);
    read_reg(32'h5, 0);
    read_reg(32'hE, 0);
    end_test("unmapped offsets");

    repeat (4) next_cycle();
    if (expected_q.size() != 0) report_failure("read responses missing at the end");
    if (aw_count != b_count) report_failure("write and response counts differ");
    total_errors = error_count + int'(dut_i.checker_i.assert_fails);
    $display("checks passed: %0d, errors: %0d", pass_count, total_errors);
    if (total_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
verilog/gpio_pkg.sv
verilog/axil_write_unit.sv
verilog/axil_read_unit.sv
verilog/gpio_input_sync.sv
verilog/gpio_regs.sv
verilog/gpio_top.sv
testbench/gpio_checker.sv
testbench/gpio_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = gpio_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
